// ==== flist.f ====
pipePkg.sv
pcReg.sv
stageReg.sv
instrDecoder.sv
regFile.sv
alu.sv
exMemReg.sv
hazardCtrl.sv
writeBack.sv
cpuTop.sv
cpuChecker.sv
tbCpu.sv

// ==== Bender.yml ====
package:
  name: cpu_pipe

sources:
  - pipePkg.sv
  - pcReg.sv
  - stageReg.sv
  - instrDecoder.sv
  - regFile.sv
  - alu.sv
  - exMemReg.sv
  - hazardCtrl.sv
  - writeBack.sv
  - cpuTop.sv
  - target: test
    files:
      - cpuChecker.sv
      - tbCpu.sv

// ==== tbCpu.sv ====
`timescale 1ns/1ps

module tbCpu;
	import pipePkg::*;

	logic clk;
	logic rst;
	logic [dataW-1:0] imemAddr;
	logic [dataW-1:0] imemData;
	logic [dataW-1:0] dmemAddr;
	logic [dataW-1:0] dmemWrData;
	logic dmemWrEn;
	logic [3:0] dmemByteEn;
	logic [dataW-1:0] dmemRdData;
	logic wbValid;
	logic [regAddrW-1:0] wbReg;
	logic [dataW-1:0] wbData;
	logic excValid;
	logic [4:0] excCode;
	logic [dataW-1:0] excPc;
	logic [dataW-1:0] badVAddr;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	logic [31:0] progTab [16][32];
	int progLen [16];
	string testName [16];
	logic [36:0] commitTab [16][24];
	int commitCnt [16];
	logic [68:0] faultTab [16][2];
	int faultCnt [16];
	int numTests;
	int cur;
	int totalLen;
	int passCount;
	int failCount;

	cpuTop dut0 (
		.clk(clk), .rst(rst), .imemAddr(imemAddr), .imemData(imemData),
		.dmemAddr(dmemAddr), .dmemWrData(dmemWrData), .dmemWrEn(dmemWrEn),
		.dmemByteEn(dmemByteEn), .dmemRdData(dmemRdData), .wbValid(wbValid), .wbReg(wbReg),
		.wbData(wbData), .excValid(excValid), .excCode(excCode), .excPc(excPc),
		.badVAddr(badVAddr)
	);

	cpuChecker watch (
		.clk(clk), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData), .excValid(excValid),
		.excCode(excCode), .excPc(excPc), .badVAddr(badVAddr)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	// ~~~~ Memory models ~~~~~~~~~~~~~~~~~
	assign imemData = imem[imemAddr[9:2]];
	assign dmemRdData = dmem[dmemAddr[9:2]];

	always @(posedge clk) begin
		if (dmemWrEn) begin
			for (int b = 0; b < 4; b++)
				if (dmemByteEn[b])
					dmem[dmemAddr[9:2]][8*b +: 8] <= dmemWrData[8*b +: 8];
		end
	end

	// ~~~~ Encoding and model ~~~~~~~~~~~~
	function automatic logic [31:0] rIns(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
		logic [4:0] rd);
		return {opSpecial, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] iIns(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] sext(logic [15:0] h);
		return {{16{h[15]}}, h};
	endfunction

	function automatic logic [31:0] fillWord(logic [31:0] addr);
		return (addr * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
	endfunction

	function automatic logic [31:0] pcAt(int idx);
		return resetPc + idx * 4;
	endfunction

	task automatic newTest(input string name);
		cur = numTests;
		numTests++;
		testName[cur] = name;
		progLen[cur] = 0;
		commitCnt[cur] = 0;
		faultCnt[cur] = 0;
	endtask

	task automatic emit(input logic [31:0] word);
		progTab[cur][progLen[cur]] = word;
		progLen[cur]++;
		totalLen++;
	endtask

	task automatic expectWb(input logic [4:0] r, input logic [31:0] v);
		commitTab[cur][commitCnt[cur]] = {r, v};
		commitCnt[cur]++;
	endtask

	task automatic expectFault(input logic [4:0] code, input logic [31:0] pc,
		input logic [31:0] bad);
		faultTab[cur][faultCnt[cur]] = {code, pc, bad};
		faultCnt[cur]++;
		expectWb(5'd26, fillWord(32'h100)); // Vector code reloads 0x100.
	endtask

	// ~~~~ Test table ~~~~~~~~~~~~~~~~~~~~
	task automatic buildTable();
		logic [15:0] rA;
		logic [15:0] rB;
		logic [15:0] rC;
		logic [15:0] rD;
		logic [15:0] rE;
		logic [15:0] rF;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] v;
		rA = $urandom(32'heb2f);
		rB = $urandom;
		rC = $urandom;
		rD = $urandom | 16'h8000;
		rE = $urandom | 16'h8000;
		rF = $urandom;
		numTests = 0;
		totalLen = 0;

		newTest("alu");
		a1 = {rA, 16'h0};
		a2 = sext(rB);
		emit(iIns(opLui, 0, 1, rA));
		expectWb(1, a1);
		emit(iIns(opAddiu, 0, 2, rB));
		expectWb(2, a2);
		emit(rIns(fnAddu, 1, 2, 3));
		expectWb(3, a1 + a2);
		emit(rIns(fnSubu, 1, 2, 4));
		expectWb(4, a1 - a2);
		emit(rIns(fnAnd, 1, 2, 5));
		expectWb(5, a1 & a2);
		emit(rIns(fnOr, 1, 2, 6));
		expectWb(6, a1 | a2);
		emit(rIns(fnSlt, 2, 1, 7));
		expectWb(7, {31'd0, $signed(a2) < $signed(a1)});
		emit(iIns(opAddi, 2, 8, 16'd5));
		expectWb(8, a2 + 32'd5);
		emit(rIns(fnAdd, 2, 2, 9));
		expectWb(9, a2 + a2);
		emit(iIns(opBeq, 0, 0, 16'hffff)); // Spin.

		newTest("forward");
		a1 = sext(rC);
		emit(iIns(opAddiu, 0, 1, rC));
		expectWb(1, a1);
		emit(rIns(fnAddu, 1, 1, 2));
		expectWb(2, a1 * 2);
		emit(rIns(fnAddu, 1, 2, 3));
		expectWb(3, a1 * 3);
		emit(iIns(opSw, 0, 3, 16'h20));
		emit(iIns(opLw, 0, 4, 16'h20));
		expectWb(4, a1 * 3);
		emit(rIns(fnAddu, 4, 1, 5)); // Load-use.
		expectWb(5, a1 * 4);
		emit(iIns(opLw, 0, 6, 16'h24));
		expectWb(6, fillWord(32'h24));
		emit(rIns(fnOr, 6, 0, 7));
		expectWb(7, fillWord(32'h24));
		emit(iIns(opBeq, 0, 0, 16'hffff));

		newTest("halfword");
		a1 = {rD, 16'h0};
		v = a1 + sext(rE);
		emit(iIns(opLui, 0, 1, rD));
		expectWb(1, a1);
		emit(iIns(opAddiu, 1, 1, rE));
		expectWb(1, v);
		emit(iIns(opSw, 0, 1, 16'h40));
		emit(iIns(opLh, 0, 2, 16'h40));
		expectWb(2, sext(v[15:0]));
		emit(iIns(opLhu, 0, 3, 16'h42));
		expectWb(3, {16'h0, v[31:16]});
		emit(iIns(opLh, 0, 4, 16'h42));
		expectWb(4, sext(v[31:16]));
		emit(iIns(opAddiu, 0, 5, rF));
		expectWb(5, sext(rF));
		emit(iIns(opSh, 0, 5, 16'h46)); // Upper lanes.
		emit(iIns(opSh, 0, 5, 16'h48)); // Lower lanes.
		emit(iIns(opLw, 0, 6, 16'h44));
		a2 = fillWord(32'h44);
		expectWb(6, {rF, a2[15:0]});
		emit(iIns(opLw, 0, 7, 16'h48));
		a2 = fillWord(32'h48);
		expectWb(7, {a2[31:16], rF});
		emit(iIns(opBeq, 0, 0, 16'hffff));

		newTest("branch");
		emit(iIns(opAddiu, 0, 1, 16'd7));
		expectWb(1, 32'd7);
		emit(iIns(opAddiu, 0, 2, 16'd7));
		expectWb(2, 32'd7);
		emit(iIns(opBeq, 1, 2, 16'd2));
		emit(iIns(opAddiu, 0, 3, 16'd1));
		emit(iIns(opAddiu, 0, 3, 16'd2));
		emit(iIns(opAddiu, 0, 4, 16'd3));
		expectWb(4, 32'd3);
		emit(iIns(opBne, 1, 4, 16'd1));
		emit(iIns(opAddiu, 0, 5, 16'd9));
		emit(iIns(opLui, 0, 6, 16'hbfc0));
		expectWb(6, 32'hbfc0_0000);
		emit(iIns(opAddiu, 6, 6, 16'h34));
		expectWb(6, pcAt(13));
		emit(rIns(fnJr, 6, 0, 0));
		emit(iIns(opAddiu, 0, 7, 16'd1));
		emit(iIns(opAddiu, 0, 7, 16'd2));
		emit(iIns(opAddiu, 0, 8, 16'd5)); // Jump target.
		expectWb(8, 32'd5);
		emit(iIns(opBeq, 0, 0, 16'hffff));

		newTest("overflow");
		emit(iIns(opLui, 0, 1, 16'h7fff));
		expectWb(1, 32'h7fff_0000);
		emit(rIns(fnAddu, 1, 1, 2));
		expectWb(2, 32'hfffe_0000);
		emit(rIns(fnAdd, 1, 1, 3));
		expectFault(excOv, pcAt(2), 32'h0);
		emit(iIns(opAddiu, 0, 4, 16'd1));
		emit(iIns(opBeq, 0, 0, 16'hffff));

		newTest("loadAlign");
		emit(iIns(opAddiu, 0, 1, 16'h10));
		expectWb(1, 32'h10);
		emit(iIns(opLw, 1, 2, 16'h2));
		expectFault(excAdEL, pcAt(1), 32'h12);
		emit(iIns(opAddiu, 0, 3, 16'd1));
		emit(iIns(opBeq, 0, 0, 16'hffff));

		newTest("storeAlign");
		emit(iIns(opAddiu, 0, 1, rA));
		expectWb(1, sext(rA));
		emit(iIns(opSh, 0, 1, 16'h101));
		expectFault(excAdES, pcAt(1), 32'h101);
		emit(iIns(opAddiu, 0, 2, 16'd1));
		emit(iIns(opBeq, 0, 0, 16'hffff));

		newTest("reserved");
		emit(iIns(opAddiu, 0, 1, 16'd3));
		expectWb(1, 32'd3);
		emit(32'hfc00_0000);
		expectFault(excRi, pcAt(1), 32'h0);
		emit(iIns(opAddiu, 0, 2, 16'd1));
		emit(iIns(opBeq, 0, 0, 16'hffff));

		newTest("jrAlign");
		emit(iIns(opLui, 0, 1, 16'hbfc0));
		expectWb(1, 32'hbfc0_0000);
		emit(iIns(opAddiu, 1, 1, 16'h12));
		expectWb(1, 32'hbfc0_0012);
		emit(rIns(fnJr, 1, 0, 0));
		expectFault(excAdEL, 32'hbfc0_0012, 32'hbfc0_0012);
		emit(iIns(opAddiu, 0, 2, 16'd1));
		emit(iIns(opBeq, 0, 0, 16'hffff));
	endtask

	// ~~~~ Test loop ~~~~~~~~~~~~~~~~~~~~~
	task automatic fillMemories();
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0;
			dmem[i] = fillWord(i * 4);
		end
	endtask

	task automatic loadTest(input int t);
		fillMemories();
		for (int i = 0; i < progLen[t]; i++)
			imem[i] = progTab[t][i];
		imem[excVector[9:2]] = iIns(opLw, 0, 26, 16'h100);
		imem[excVector[9:2] + 1] = iIns(opBeq, 0, 0, 16'hffff);
		watch.startTest(testName[t]);
		for (int i = 0; i < commitCnt[t]; i++)
			watch.expectCommit(commitTab[t][i][36:32], commitTab[t][i][31:0]);
		for (int i = 0; i < faultCnt[t]; i++)
			watch.expectExc(faultTab[t][i][68:64], faultTab[t][i][63:32], faultTab[t][i][31:0]);
	endtask

	task automatic runTest(input int t);
		int cycles;
		bit ok;
		@(posedge clk);
		#1;
		rst = 1'b0;
		@(posedge clk);
		#1;
		loadTest(t);
		repeat (7) @(posedge clk);
		#1;
		rst = 1'b1;
		cycles = 0;
		while (watch.pending() > 0 && cycles < progLen[t] * 20) begin
			@(posedge clk);
			cycles++;
		end
		repeat (12) @(posedge clk); // Window for stray events.
		watch.endTest(ok);
		if (ok)
			passCount++;
		else
			failCount++;
	endtask

	initial begin
		rst = 1'b0;
		passCount = 0;
		failCount = 0;
		fillMemories();
		buildTable();
		for (int t = 0; t < numTests; t++)
			runTest(t);
		$display("Tests run: %0d, passed: %0d, failed: %0d", numTests, passCount, failCount);
		if (failCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin
		int limit;
		@(posedge clk);
		limit = totalLen * 20 + numTests * 40;
		repeat (limit) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== cpuChecker.sv ====
`timescale 1ns/1ps

module cpuChecker (
	input logic clk,
	input logic wbValid,
	input logic [pipePkg::regAddrW-1:0] wbReg,
	input logic [pipePkg::dataW-1:0] wbData,
	input logic excValid,
	input logic [4:0] excCode,
	input logic [pipePkg::dataW-1:0] excPc,
	input logic [pipePkg::dataW-1:0] badVAddr
);

	logic [36:0] commitQ [$]; // {reg, value}.
	logic [68:0] faultQ [$]; // {code, pc, bad address}.
	string testName;
	int errors;
	int nCommit;
	int nFault;

	task automatic startTest(input string name);
		testName = name;
		errors = 0;
		nCommit = 0;
		nFault = 0;
		commitQ.delete();
		faultQ.delete();
	endtask

	task automatic expectCommit(input logic [4:0] r, input logic [31:0] v);
		commitQ.push_back({r, v});
	endtask

	task automatic expectExc(input logic [4:0] code, input logic [31:0] pc,
		input logic [31:0] bad);
		faultQ.push_back({code, pc, bad});
	endtask

	function automatic int pending();
		return commitQ.size() + faultQ.size();
	endfunction

	// ~~~~ Port compare ~~~~~~~~~~~~~~~~~~
	task automatic compareCommit();
		logic [36:0] exp;
		nCommit++;
		if (commitQ.size() == 0) begin
			$display("Unexpected commit to register %0d with value %h in %s", wbReg, wbData,
				testName);
			errors++;
		end else begin
			exp = commitQ.pop_front();
			if (wbReg !== exp[36:32]) begin
				$display("Fail wbReg in %s: expected %h, got %h", testName, exp[36:32], wbReg);
				errors++;
			end
			if (wbData !== exp[31:0]) begin
				$display("Fail wbData in %s: expected %h, got %h", testName, exp[31:0], wbData);
				errors++;
			end
		end
	endtask

	task automatic compareFault();
		logic [68:0] exp;
		nFault++;
		if (faultQ.size() == 0) begin
			$display("Unexpected exception with code %0d at pc %h in %s", excCode, excPc,
				testName);
			errors++;
		end else begin
			exp = faultQ.pop_front();
			if (excCode !== exp[68:64]) begin
				$display("Fail excCode in %s: expected %h, got %h", testName, exp[68:64], excCode);
				errors++;
			end
			if (excPc !== exp[63:32]) begin
				$display("Fail excPc in %s: expected %h, got %h", testName, exp[63:32], excPc);
				errors++;
			end
			if (badVAddr !== exp[31:0]) begin
				$display("Fail badVAddr in %s: expected %h, got %h", testName, exp[31:0], badVAddr);
				errors++;
			end
		end
	endtask

	// Ports are stable mid-cycle.
	always @(negedge clk) begin
		if (wbValid === 1'b1)
			compareCommit();
		if (excValid === 1'b1)
			compareFault();
	end

	task automatic endTest(output bit ok);
		logic [36:0] c;
		logic [68:0] f;
		while (commitQ.size() > 0) begin
			c = commitQ.pop_front();
			$display("Missing commit to register %0d with value %h in %s", c[36:32], c[31:0],
				testName);
			errors++;
		end
		while (faultQ.size() > 0) begin
			f = faultQ.pop_front();
			$display("Missing exception with code %0d at pc %h in %s", f[68:64], f[63:32],
				testName);
			errors++;
		end
		if (errors == 0)
			$display("Test %s: ok, %0d commits, %0d exceptions", testName, nCommit, nFault);
		else
			$display("Test %s: %0d errors", testName, errors);
		ok = errors == 0;
	endtask

endmodule

// ==== cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
	input logic clk,
	input logic rst,
	output logic [pipePkg::dataW-1:0] imemAddr,
	input logic [pipePkg::dataW-1:0] imemData,
	output logic [pipePkg::dataW-1:0] dmemAddr,
	output logic [pipePkg::dataW-1:0] dmemWrData,
	output logic dmemWrEn,
	output logic [3:0] dmemByteEn,
	input logic [pipePkg::dataW-1:0] dmemRdData,
	output logic wbValid,
	output logic [pipePkg::regAddrW-1:0] wbReg,
	output logic [pipePkg::dataW-1:0] wbData,
	output logic excValid,
	output logic [4:0] excCode,
	output logic [pipePkg::dataW-1:0] excPc,
	output logic [pipePkg::dataW-1:0] badVAddr
);
	import pipePkg::*;

	logic [dataW-1:0] pc;
	logic fetchAdEL;
	pcSelT pcSel;
	logic pcWrEn;
	logic ifIdWrEn;
	logic ifIdFlush;
	logic idExFlush;
	logic exMemFlush;
	logic suppressMem;
	ifIdT ifIdD;
	ifIdT ifIdQ;
	idExT idExD;
	idExT idExQ;
	memWbT memWbD;
	memWbT memWbQ;
	logic [1:0] fwdSelA;
	logic [1:0] fwdSelB;
	logic [dataW-1:0] opA;
	logic [dataW-1:0] opB;
	logic [dataW-1:0] aluResult;
	logic overflow;
	logic branchTaken;
	logic [dataW-1:0] branchTarget;
	logic [dataW-1:0] aluResultMem;
	logic [dataW-1:0] storeDataMem;
	logic [dataW-1:0] pcMem;
	logic memRdMem;
	logic memWrMem;
	logic regWrMem;
	memSizeT memSizeMem;
	wbSelT wbSelMem;
	logic [regAddrW-1:0] destMem;
	logic excValidMem;
	logic [4:0] excCodeMem;
	logic [dataW-1:0] wbDataWb;

	// ~~~~ Fetch and decode ~~~~~~~~~~~~~~
	pcReg fetchPc (
		.clk(clk), .rst(rst), .wrEn(pcWrEn), .pcSel(pcSel),
		.branchTarget(branchTarget), .jrTarget(opA), .pc(pc), .fetchAdEL(fetchAdEL)
	);

	assign imemAddr = pc;
	assign ifIdD = '{pc: pc, instr: imemData, fetchAdEL: fetchAdEL};

	stageReg #(.payloadT(ifIdT)) ifIdReg (
		.clk(clk), .rst(rst), .wrEn(ifIdWrEn), .flush(ifIdFlush), .d(ifIdD), .q(ifIdQ)
	);

	assign idExD.pc = ifIdQ.pc;

	instrDecoder decoder (
		.instr(ifIdQ.instr), .fetchAdEL(ifIdQ.fetchAdEL),
		.rs(idExD.rs), .rt(idExD.rt), .dest(idExD.dest), .imm(idExD.imm),
		.aluOp(idExD.aluOp), .aluSrcImm(idExD.aluSrcImm), .ovCheck(idExD.ovCheck),
		.memRd(idExD.memRd), .memWr(idExD.memWr), .regWr(idExD.regWr),
		.isBranchEq(idExD.isBranchEq), .isBranchNe(idExD.isBranchNe), .isJr(idExD.isJr),
		.memSize(idExD.memSize), .wbSel(idExD.wbSel),
		.exc(idExD.exc), .excCode(idExD.excCode)
	);

	regFile regs (
		.clk(clk), .rst(rst), .rdAddrA(idExD.rs), .rdAddrB(idExD.rt),
		.wrAddr(memWbQ.dest), .wrEn(memWbQ.regWr), .wrData(wbDataWb),
		.rdDataA(idExD.rsVal), .rdDataB(idExD.rtVal)
	);

	stageReg #(.payloadT(idExT)) idExReg (
		.clk(clk), .rst(rst), .wrEn(1'b1), .flush(idExFlush), .d(idExD), .q(idExQ)
	);

	// ~~~~ Execute ~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (fwdSelA)
			fwdMem: opA = aluResultMem;
			fwdWb: opA = wbDataWb;
			default: opA = idExQ.rsVal;
		endcase
		case (fwdSelB)
			fwdMem: opB = aluResultMem;
			fwdWb: opB = wbDataWb;
			default: opB = idExQ.rtVal;
		endcase
	end

	alu execAlu (
		.op(idExQ.aluOp), .a(opA), .b(idExQ.aluSrcImm ? idExQ.imm : opB),
		.ovCheck(idExQ.ovCheck), .result(aluResult), .overflow(overflow)
	);

	assign branchTaken = (idExQ.isBranchEq && opA == opB) || (idExQ.isBranchNe && opA != opB);
	assign branchTarget = idExQ.pc + 32'd4 + {idExQ.imm[dataW-3:0], 2'b00};

	exMemReg exMem (
		.clk(clk), .rst(rst), .flush(exMemFlush), .aluResult(aluResult),
		.storeData(opB), .pcIn(idExQ.pc), .overflow(overflow), .memRd(idExQ.memRd),
		.memWr(idExQ.memWr), .regWr(idExQ.regWr), .excIn(idExQ.exc),
		.memSize(idExQ.memSize), .wbSel(idExQ.wbSel), .dest(idExQ.dest),
		.excCodeIn(idExQ.excCode), .aluResultMem(aluResultMem), .storeDataMem(storeDataMem),
		.pcMem(pcMem), .memRdMem(memRdMem), .memWrMem(memWrMem), .regWrMem(regWrMem),
		.memSizeMem(memSizeMem), .wbSelMem(wbSelMem), .destMem(destMem),
		.excValidMem(excValidMem), .excCodeMem(excCodeMem), .badVAddr(badVAddr)
	);

	hazardCtrl hazard (
		.rsEx(idExQ.rs), .rtEx(idExQ.rt), .destMem(destMem), .destWb(memWbQ.dest),
		.rsId(idExD.rs), .rtId(idExD.rt), .destEx(idExQ.dest), .regWrMem(regWrMem),
		.regWrWb(memWbQ.regWr), .memRdEx(idExQ.memRd), .branchTaken(branchTaken),
		.isJrEx(idExQ.isJr), .excValidMem(excValidMem), .fwdSelA(fwdSelA),
		.fwdSelB(fwdSelB), .pcSel(pcSel), .pcWrEn(pcWrEn), .ifIdWrEn(ifIdWrEn),
		.ifIdFlush(ifIdFlush), .idExFlush(idExFlush), .exMemFlush(exMemFlush),
		.suppressMem(suppressMem)
	);

	// ~~~~ Memory and writeback ~~~~~~~~~~
	writeBack memShape (
		.memSize(memSizeMem), .addr(aluResultMem), .storeData(storeDataMem),
		.rawLoad(dmemRdData), .aluResult(aluResultMem), .wbSel(wbSelMem),
		.byteEn(dmemByteEn), .shapedStore(dmemWrData), .wbData()
	);

	assign dmemAddr = aluResultMem;
	assign dmemWrEn = memWrMem && !suppressMem;
	assign excValid = excValidMem;
	assign excCode = excCodeMem;
	assign excPc = pcMem;

	assign memWbD = '{
		regWr: regWrMem && !suppressMem,
		dest: destMem,
		wbSel: wbSelMem,
		memSize: memSizeMem,
		aluResult: aluResultMem,
		rawLoad: memRdMem ? dmemRdData : '0
	};

	stageReg #(.payloadT(memWbT)) memWbReg (
		.clk(clk), .rst(rst), .wrEn(1'b1), .flush(1'b0), .d(memWbD), .q(memWbQ)
	);

	writeBack wbSelect (
		.memSize(memWbQ.memSize), .addr(memWbQ.aluResult), .storeData('0),
		.rawLoad(memWbQ.rawLoad), .aluResult(memWbQ.aluResult), .wbSel(memWbQ.wbSel),
		.byteEn(), .shapedStore(), .wbData(wbDataWb)
	);

	assign wbValid = memWbQ.regWr && memWbQ.dest != '0;
	assign wbReg = memWbQ.dest;
	assign wbData = wbDataWb;

endmodule

// ==== writeBack.sv ====
`timescale 1ns/1ps

module writeBack (
	input pipePkg::memSizeT memSize,
	input logic [pipePkg::dataW-1:0] addr,
	input logic [pipePkg::dataW-1:0] storeData,
	input logic [pipePkg::dataW-1:0] rawLoad,
	input logic [pipePkg::dataW-1:0] aluResult,
	input pipePkg::wbSelT wbSel,
	output logic [3:0] byteEn,
	output logic [pipePkg::dataW-1:0] shapedStore,
	output logic [pipePkg::dataW-1:0] wbData
);
	import pipePkg::*;

	logic [15:0] half;
	logic [dataW-1:0] loadVal;

	assign half = addr[1] ? rawLoad[31:16] : rawLoad[15:0];

	always_comb begin
		if (memSize == memWord) begin
			byteEn = 4'b1111;
			shapedStore = storeData;
		end else begin
			byteEn = addr[1] ? 4'b1100 : 4'b0011;
			shapedStore = {2{storeData[15:0]}}; // Copied to both lanes.
		end
	end

	always_comb begin
		case (memSize)
			memHalfS: loadVal = {{16{half[15]}}, half};
			memHalfU: loadVal = {16'h0, half};
			default: loadVal = rawLoad;
		endcase
	end

	assign wbData = (wbSel == wbLoad) ? loadVal : aluResult;

endmodule

// ==== hazardCtrl.sv ====
`timescale 1ns/1ps

module hazardCtrl (
	input logic [pipePkg::regAddrW-1:0] rsEx,
	input logic [pipePkg::regAddrW-1:0] rtEx,
	input logic [pipePkg::regAddrW-1:0] destMem,
	input logic [pipePkg::regAddrW-1:0] destWb,
	input logic [pipePkg::regAddrW-1:0] rsId,
	input logic [pipePkg::regAddrW-1:0] rtId,
	input logic [pipePkg::regAddrW-1:0] destEx,
	input logic regWrMem,
	input logic regWrWb,
	input logic memRdEx,
	input logic branchTaken,
	input logic isJrEx,
	input logic excValidMem,
	output logic [1:0] fwdSelA,
	output logic [1:0] fwdSelB,
	output pipePkg::pcSelT pcSel,
	output logic pcWrEn,
	output logic ifIdWrEn,
	output logic ifIdFlush,
	output logic idExFlush,
	output logic exMemFlush,
	output logic suppressMem
);
	import pipePkg::*;

	logic loadUse;

	// MEM result is younger than WB.
	assign fwdSelA = (regWrMem && destMem != '0 && destMem == rsEx) ? fwdMem :
		(regWrWb && destWb != '0 && destWb == rsEx) ? fwdWb : fwdReg;
	assign fwdSelB = (regWrMem && destMem != '0 && destMem == rtEx) ? fwdMem :
		(regWrWb && destWb != '0 && destWb == rtEx) ? fwdWb : fwdReg;

	assign loadUse = memRdEx && destEx != '0 && (destEx == rsId || destEx == rtId);

	assign exMemFlush = excValidMem;
	assign suppressMem = excValidMem; // Faulting op must not write.

	always_comb begin
		pcSel = pcSeq;
		pcWrEn = 1'b1;
		ifIdWrEn = 1'b1;
		ifIdFlush = 1'b0;
		idExFlush = 1'b0;
		if (excValidMem) begin
			pcSel = pcExc;
			ifIdFlush = 1'b1;
			idExFlush = 1'b1;
		end else if (isJrEx || branchTaken) begin
			pcSel = isJrEx ? pcJr : pcBranch;
			ifIdFlush = 1'b1;
			idExFlush = 1'b1;
		end else if (loadUse) begin
			pcWrEn = 1'b0;
			ifIdWrEn = 1'b0;
			idExFlush = 1'b1; // Bubble into EX.
		end
	end

endmodule

// ==== exMemReg.sv ====
`timescale 1ns/1ps

module exMemReg (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic [pipePkg::dataW-1:0] aluResult,
	input logic [pipePkg::dataW-1:0] storeData,
	input logic [pipePkg::dataW-1:0] pcIn,
	input logic overflow,
	input logic memRd,
	input logic memWr,
	input logic regWr,
	input logic excIn,
	input pipePkg::memSizeT memSize,
	input pipePkg::wbSelT wbSel,
	input logic [pipePkg::regAddrW-1:0] dest,
	input logic [4:0] excCodeIn,
	output logic [pipePkg::dataW-1:0] aluResultMem,
	output logic [pipePkg::dataW-1:0] storeDataMem,
	output logic [pipePkg::dataW-1:0] pcMem,
	output logic memRdMem,
	output logic memWrMem,
	output logic regWrMem,
	output pipePkg::memSizeT memSizeMem,
	output pipePkg::wbSelT wbSelMem,
	output logic [pipePkg::regAddrW-1:0] destMem,
	output logic excValidMem,
	output logic [4:0] excCodeMem,
	output logic [pipePkg::dataW-1:0] badVAddr
);
	import pipePkg::*;

	logic misaligned;

	assign misaligned = (memSize == memWord) ? aluResult[1:0] != 2'b00 : aluResult[0];

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			aluResultMem <= '0;
			storeDataMem <= '0;
			pcMem <= '0;
			memRdMem <= 1'b0;
			memWrMem <= 1'b0;
			regWrMem <= 1'b0;
			memSizeMem <= memWord;
			wbSelMem <= wbAlu;
			destMem <= '0;
		end else begin
			aluResultMem <= aluResult;
			storeDataMem <= storeData;
			pcMem <= pcIn;
			memRdMem <= memRd;
			memWrMem <= memWr;
			regWrMem <= regWr;
			memSizeMem <= memSize;
			wbSelMem <= wbSel;
			destMem <= dest;
		end
	end

	// ~~~~ Exception priority ~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			excValidMem <= 1'b0;
			excCodeMem <= '0;
			badVAddr <= '0;
		end else if (excIn) begin
			excValidMem <= 1'b1;
			excCodeMem <= excCodeIn;
			badVAddr <= (excCodeIn == excAdEL) ? pcIn : '0; // Fetch fault.
		end else if (overflow) begin
			excValidMem <= 1'b1;
			excCodeMem <= excOv;
			badVAddr <= '0;
		end else if (memWr && misaligned) begin
			excValidMem <= 1'b1;
			excCodeMem <= excAdES;
			badVAddr <= aluResult;
		end else if (memRd && misaligned) begin
			excValidMem <= 1'b1;
			excCodeMem <= excAdEL;
			badVAddr <= aluResult;
		end else begin
			excValidMem <= 1'b0;
			excCodeMem <= '0;
			badVAddr <= '0;
		end
	end

endmodule

// ==== alu.sv ====
`timescale 1ns/1ps

module alu (
	input pipePkg::aluOpT op,
	input logic [pipePkg::dataW-1:0] a,
	input logic [pipePkg::dataW-1:0] b,
	input logic ovCheck,
	output logic [pipePkg::dataW-1:0] result,
	output logic overflow
);
	import pipePkg::*;

	logic [dataW-1:0] sum;
	logic [dataW-1:0] diff;

	assign sum = a + b;
	assign diff = a - b;

	always_comb begin
		overflow = 1'b0;
		case (op)
			aluAdd: begin
				result = sum;
				overflow = ovCheck && a[dataW-1] == b[dataW-1] && sum[dataW-1] != a[dataW-1];
			end
			aluSub: begin
				result = diff;
				overflow = ovCheck && a[dataW-1] != b[dataW-1] && diff[dataW-1] != a[dataW-1];
			end
			aluAnd: result = a & b;
			aluOr: result = a | b;
			aluSlt: result = {{(dataW-1){1'b0}}, $signed(a) < $signed(b)};
			aluLui: result = {b[15:0], 16'h0}; // Upper half load.
			default: result = sum;
		endcase
	end

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic rst,
	input logic [pipePkg::regAddrW-1:0] rdAddrA,
	input logic [pipePkg::regAddrW-1:0] rdAddrB,
	input logic [pipePkg::regAddrW-1:0] wrAddr,
	input logic wrEn,
	input logic [pipePkg::dataW-1:0] wrData,
	output logic [pipePkg::dataW-1:0] rdDataA,
	output logic [pipePkg::dataW-1:0] rdDataB
);
	import pipePkg::*;

	logic [dataW-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && wrAddr != '0) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Same-cycle write shows through.
	assign rdDataA = (rdAddrA == '0) ? '0 :
		(wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
	assign rdDataB = (rdAddrB == '0) ? '0 :
		(wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// ==== instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder (
	input logic [pipePkg::dataW-1:0] instr,
	input logic fetchAdEL,
	output logic [pipePkg::regAddrW-1:0] rs,
	output logic [pipePkg::regAddrW-1:0] rt,
	output logic [pipePkg::regAddrW-1:0] dest,
	output logic [pipePkg::dataW-1:0] imm,
	output pipePkg::aluOpT aluOp,
	output logic aluSrcImm,
	output logic ovCheck,
	output logic memRd,
	output logic memWr,
	output logic regWr,
	output logic isBranchEq,
	output logic isBranchNe,
	output logic isJr,
	output pipePkg::memSizeT memSize,
	output pipePkg::wbSelT wbSel,
	output logic exc,
	output logic [4:0] excCode
);
	import pipePkg::*;

	logic known;

	assign rs = instr[25:21];
	assign rt = instr[20:16];

	always_comb begin
		known = 1'b1;
		dest = instr[20:16];
		imm = {{16{instr[15]}}, instr[15:0]};
		aluOp = aluAdd;
		aluSrcImm = 1'b1;
		ovCheck = 1'b0;
		memRd = 1'b0;
		memWr = 1'b0;
		regWr = 1'b0;
		isBranchEq = 1'b0;
		isBranchNe = 1'b0;
		isJr = 1'b0;
		memSize = memWord;
		wbSel = wbAlu;
		case (instr[31:26])
			opSpecial: begin
				dest = instr[15:11];
				aluSrcImm = 1'b0;
				regWr = 1'b1;
				case (instr[5:0])
					fnAddu: aluOp = aluAdd;
					fnAdd: ovCheck = 1'b1;
					fnSubu: aluOp = aluSub;
					fnSub: begin
						aluOp = aluSub;
						ovCheck = 1'b1;
					end
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnSlt: aluOp = aluSlt;
					fnJr: begin
						regWr = 1'b0;
						isJr = 1'b1;
					end
					default: begin
						regWr = 1'b0;
						known = instr == '0; // Zero word is the nop.
					end
				endcase
			end
			opAddiu: regWr = 1'b1;
			opAddi: begin
				regWr = 1'b1;
				ovCheck = 1'b1;
			end
			opLui: begin
				regWr = 1'b1;
				aluOp = aluLui;
				imm = {16'h0, instr[15:0]};
			end
			opLw, opLh, opLhu: begin
				regWr = 1'b1;
				memRd = 1'b1;
				wbSel = wbLoad;
				memSize = (instr[31:26] == opLw) ? memWord :
					(instr[31:26] == opLh) ? memHalfS : memHalfU;
			end
			opSw, opSh: begin
				memWr = 1'b1;
				memSize = (instr[31:26] == opSw) ? memWord : memHalfU;
			end
			opBeq: begin
				aluSrcImm = 1'b0;
				isBranchEq = 1'b1;
			end
			opBne: begin
				aluSrcImm = 1'b0;
				isBranchNe = 1'b1;
			end
			default: known = 1'b0;
		endcase

		exc = fetchAdEL || !known;
		excCode = fetchAdEL ? excAdEL : (known ? 5'd0 : excRi);
		if (exc) begin
			regWr = 1'b0;
			memRd = 1'b0;
			memWr = 1'b0;
			isBranchEq = 1'b0;
			isBranchNe = 1'b0;
			isJr = 1'b0;
		end
	end

endmodule

// ==== stageReg.sv ====
`timescale 1ns/1ps

module stageReg #(
	parameter type payloadT = logic
) (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input logic flush,
	input payloadT d,
	output payloadT q
);

	// Flush wins over a held stage.
	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			q <= '0; // Bubble.
		end else if (wrEn) begin
			q <= d;
		end
	end

endmodule

// ==== pcReg.sv ====
`timescale 1ns/1ps

module pcReg (
	input logic clk,
	input logic rst,
	input logic wrEn,
	input pipePkg::pcSelT pcSel,
	input logic [pipePkg::dataW-1:0] branchTarget,
	input logic [pipePkg::dataW-1:0] jrTarget,
	output logic [pipePkg::dataW-1:0] pc,
	output logic fetchAdEL
);
	import pipePkg::*;

	logic [dataW-1:0] nextPc;

	always_comb begin
		case (pcSel)
			pcBranch: nextPc = branchTarget;
			pcJr: nextPc = jrTarget;
			pcExc: nextPc = excVector;
			default: nextPc = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= resetPc;
			fetchAdEL <= 1'b0;
		end else if (wrEn) begin
			pc <= nextPc;
			fetchAdEL <= nextPc[1:0] != 2'b00; // Tag rides with the fetch.
		end
	end

endmodule

// ==== pipePkg.sv ====
package pipePkg;

	localparam int dataW = 32;
	localparam int regAddrW = 5;

	localparam logic [dataW-1:0] resetPc = 32'hbfc0_0000;
	localparam logic [dataW-1:0] excVector = 32'hbfc0_0380;

	localparam logic [4:0] excOv = 5'd12;
	localparam logic [4:0] excAdEL = 5'd4;
	localparam logic [4:0] excAdES = 5'd5;
	localparam logic [4:0] excRi = 5'd10;

	// ~~~~ Opcodes ~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [5:0] opSpecial = 6'h00;
	localparam logic [5:0] opBeq = 6'h04;
	localparam logic [5:0] opBne = 6'h05;
	localparam logic [5:0] opAddi = 6'h08;
	localparam logic [5:0] opAddiu = 6'h09;
	localparam logic [5:0] opLui = 6'h0f;
	localparam logic [5:0] opLh = 6'h21;
	localparam logic [5:0] opLw = 6'h23;
	localparam logic [5:0] opLhu = 6'h25;
	localparam logic [5:0] opSh = 6'h29;
	localparam logic [5:0] opSw = 6'h2b;

	localparam logic [5:0] fnJr = 6'h08;
	localparam logic [5:0] fnAdd = 6'h20;
	localparam logic [5:0] fnAddu = 6'h21;
	localparam logic [5:0] fnSub = 6'h22;
	localparam logic [5:0] fnSubu = 6'h23;
	localparam logic [5:0] fnAnd = 6'h24;
	localparam logic [5:0] fnOr = 6'h25;
	localparam logic [5:0] fnSlt = 6'h2a;

	localparam logic [1:0] fwdReg = 2'd0;
	localparam logic [1:0] fwdMem = 2'd1;
	localparam logic [1:0] fwdWb = 2'd2;

	// ~~~~ Types ~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpT;
	typedef enum logic [1:0] {memWord, memHalfS, memHalfU} memSizeT;
	typedef enum logic [1:0] {pcSeq, pcBranch, pcJr, pcExc} pcSelT;
	typedef enum logic {wbAlu, wbLoad} wbSelT;

	typedef struct packed {
		logic [dataW-1:0] pc;
		logic [dataW-1:0] instr;
		logic fetchAdEL;
	} ifIdT;

	typedef struct packed {
		logic [dataW-1:0] pc;
		logic [dataW-1:0] rsVal;
		logic [dataW-1:0] rtVal;
		logic [regAddrW-1:0] rs;
		logic [regAddrW-1:0] rt;
		logic [regAddrW-1:0] dest;
		logic [dataW-1:0] imm;
		aluOpT aluOp;
		logic aluSrcImm;
		logic ovCheck;
		logic memRd;
		logic memWr;
		memSizeT memSize;
		logic regWr;
		wbSelT wbSel;
		logic isBranchEq;
		logic isBranchNe;
		logic isJr;
		logic exc;
		logic [4:0] excCode;
	} idExT;

	typedef struct packed {
		logic regWr;
		logic [regAddrW-1:0] dest;
		wbSelT wbSel;
		memSizeT memSize;
		logic [dataW-1:0] aluResult;
		logic [dataW-1:0] rawLoad;
	} memWbT;

endpackage
